/* common/pid_fmt_pkg.sv */
package pid_fmt_pkg;

	// Field widths of one sample
	localparam int CMD_W  = 8;
	localparam int ALT_W  = 16;
	localparam int GAIN_W = 8;

	// Internal arithmetic widths
	// Error covers target 0..4080 minus altitude 0..65535, with headroom for the delta
	localparam int ERR_W  = 18;
	localparam int ACC_W  = 24;
	localparam int TERM_W = 40;

	// Actuator output width
	localparam int OUT_W  = 15;

	// Setpoint command byte, unsigned
	typedef logic [CMD_W-1:0] cmd_t;

	// Measured or target altitude, unsigned
	typedef logic [ALT_W-1:0] alt_t;

	// Gain, plain unsigned integer
	typedef logic [GAIN_W-1:0] gain_t;

	// Error and error delta, two's complement
	typedef logic signed [ERR_W-1:0] err_t;

	// Integrator state
	typedef logic signed [ACC_W-1:0] acc_t;

	// P, I, D products and their sum
	typedef logic signed [TERM_W-1:0] term_t;

	// Actuator value
	typedef logic [OUT_W-1:0] out_t;

	// Top of the actuator range
	localparam out_t OUT_MAX = 15'd32767;

endpackage

/* common/pid_ctl_pkg.sv */
package pid_ctl_pkg;

	// Command byte is the target altitude in units of 16
	localparam int SETPOINT_SHIFT = 4;

	// Fraction bits removed from the term sum
	// Arithmetic shift, so rounding is toward minus infinity
	localparam int GAIN_FRAC = 6;

	// Anti-windup bound on the integrator, symmetric
	localparam int INT_LIMIT = 1 << 20;

	// Input valid to output valid, one cycle per stage
	localparam int PIPE_LATENCY = 3;

	// Error stage state
	// PHASE_FIRST means no previous error exists yet
	typedef enum logic {
		PHASE_FIRST,
		PHASE_RUN
	} pid_phase_e;

endpackage

/* src/pid_error_calc.sv */
`timescale 1ns/1ps

module pid_error_calc
	import pid_fmt_pkg::*;
	import pid_ctl_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  sink_data_valid,
	input  cmd_t  sink_command,
	input  alt_t  sink_data,
	input  gain_t sink_kp,
	input  gain_t sink_ki,
	input  gain_t sink_kd,
	output logic  err_valid,
	output err_t  error,
	output err_t  delta,
	output gain_t kp,
	output gain_t ki,
	output gain_t kd
);

	alt_t       target;
	err_t       err_next;
	err_t       delta_next;
	err_t       prev_err;
	pid_phase_e phase;

	always_comb begin
		// Scale the setpoint byte up to altitude units
		target = alt_t'(sink_command) << SETPOINT_SHIFT;
		// Both operands zero extended, result signed
		err_next = err_t'(target) - err_t'(sink_data);
		// No history on the first sample, so no derivative kick
		if (phase == PHASE_FIRST)
			delta_next = '0;
		else
			delta_next = err_next - prev_err;
	end

	// Control state and error history
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			err_valid <= 1'b0;
			prev_err  <= '0;
			phase     <= PHASE_FIRST;
		end else begin
			err_valid <= sink_data_valid;
			if (sink_data_valid) begin
				prev_err <= err_next;
				phase    <= PHASE_RUN;
			end
		end
	end

	// Sample payload, gains stay aligned with their own error
	always_ff @(posedge clk) begin
		if (sink_data_valid) begin
			error <= err_next;
			delta <= delta_next;
			kp    <= sink_kp;
			ki    <= sink_ki;
			kd    <= sink_kd;
		end
	end

endmodule

/* src/pid_prop_path.sv */
`timescale 1ns/1ps

module pid_prop_path
	import pid_fmt_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  err_valid,
	input  err_t  error,
	input  gain_t kp,
	output logic  p_valid,
	output term_t p_term
);

	term_t p_next;

	// Gain zero extends, error sign extends
	// Product is signed in the full term width
	always_comb begin
		p_next = term_t'(error) * term_t'(kp);
	end

	// Valid runs one cycle behind the error stage
	always_ff @(posedge clk) begin
		if (!rst_n)
			p_valid <= 1'b0;
		else
			p_valid <= err_valid;
	end

	// Product register
	always_ff @(posedge clk) begin
		if (err_valid)
			p_term <= p_next;
	end

endmodule

/* src/pid_integ_deriv_path.sv */
`timescale 1ns/1ps

module pid_integ_deriv_path
	import pid_fmt_pkg::*;
	import pid_ctl_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  err_valid,
	input  err_t  error,
	input  err_t  delta,
	input  gain_t ki,
	input  gain_t kd,
	output logic  id_valid,
	output term_t i_term,
	output term_t d_term
);

	// Integrator and its next value
	acc_t acc;
	acc_t acc_new;

	// One extra bit so the raw sum cannot wrap
	logic signed [ACC_W:0] acc_sum;

	term_t i_next;
	term_t d_next;

	always_comb begin
		acc_sum = (ACC_W+1)'(acc) + (ACC_W+1)'(error);

		// Anti-windup, hold the accumulator inside +-INT_LIMIT
		if (acc_sum > (ACC_W+1)'(INT_LIMIT))
			acc_new = acc_t'(INT_LIMIT);
		else if (acc_sum < -(ACC_W+1)'(INT_LIMIT))
			acc_new = -acc_t'(INT_LIMIT);
		else
			acc_new = acc_t'(acc_sum);

		// Integral uses the updated value, same cycle
		i_next = term_t'(acc_new) * term_t'(ki);

		// Derivative straight from the delta, unfiltered
		d_next = term_t'(delta) * term_t'(kd);
	end

	// Control state, integrator cleared on reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_valid <= 1'b0;
			acc      <= '0;
		end else begin
			id_valid <= err_valid;
			if (err_valid)
				acc <= acc_new;
		end
	end

	// I and D products registered together
	always_ff @(posedge clk) begin
		if (err_valid) begin
			i_term <= i_next;
			d_term <= d_next;
		end
	end

endmodule

/* src/pid_output_stage.sv */
`timescale 1ns/1ps

module pid_output_stage
	import pid_fmt_pkg::*;
	import pid_ctl_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  p_valid,
	input  term_t p_term,
	input  term_t i_term,
	input  term_t d_term,
	output logic  source_data_valid,
	output out_t  source_data
);

	term_t sum;
	term_t scaled;
	out_t  sat;

	always_comb begin
		// Full width sum, no overflow at these magnitudes
		sum = p_term + i_term + d_term;

		// Drop the fraction bits, floor rounding
		scaled = sum >>> GAIN_FRAC;

		// Clamp to the actuator range
		if (scaled < 0)
			sat = '0;
		else if (scaled > term_t'(OUT_MAX))
			sat = OUT_MAX;
		else
			sat = out_t'(scaled);
	end

	// p_valid and id_valid always coincide, one is enough
	always_ff @(posedge clk) begin
		if (!rst_n)
			source_data_valid <= 1'b0;
		else
			source_data_valid <= p_valid;
	end

	// Actuator register, only meaningful with its valid
	always_ff @(posedge clk) begin
		if (p_valid)
			source_data <= sat;
	end

endmodule

/* src/pid_altitude.sv */
`timescale 1ns/1ps

module pid_altitude
	import pid_fmt_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  sink_data_valid,
	input  cmd_t  sink_command,
	input  alt_t  sink_data,
	input  gain_t sink_kp,
	input  gain_t sink_ki,
	input  gain_t sink_kd,
	output logic  source_data_valid,
	output out_t  source_data
);

	// Error stage outputs, shared by both paths
	logic  err_valid;
	err_t  error;
	err_t  delta;
	gain_t kp;
	gain_t ki;
	gain_t kd;

	// Path outputs
	logic  p_valid;
	term_t p_term;
	term_t i_term;
	term_t d_term;

	// Stage 1, error and delta
	pid_error_calc i_pid_error_calc (
		.clk             (clk),
		.rst_n           (rst_n),
		.sink_data_valid (sink_data_valid),
		.sink_command    (sink_command),
		.sink_data       (sink_data),
		.sink_kp         (sink_kp),
		.sink_ki         (sink_ki),
		.sink_kd         (sink_kd),
		.err_valid       (err_valid),
		.error           (error),
		.delta           (delta),
		.kp              (kp),
		.ki              (ki),
		.kd              (kd)
	);

	// Stage 2a, proportional product
	pid_prop_path i_pid_prop_path (
		.clk       (clk),
		.rst_n     (rst_n),
		.err_valid (err_valid),
		.error     (error),
		.kp        (kp),
		.p_valid   (p_valid),
		.p_term    (p_term)
	);

	// Stage 2b, integrator and derivative in parallel with 2a
	// Its valid matches p_valid, so it stays open here
	pid_integ_deriv_path i_pid_integ_deriv_path (
		.clk       (clk),
		.rst_n     (rst_n),
		.err_valid (err_valid),
		.error     (error),
		.delta     (delta),
		.ki        (ki),
		.kd        (kd),
		.id_valid  (),
		.i_term    (i_term),
		.d_term    (d_term)
	);

	// Stage 3, sum, rescale, saturate
	pid_output_stage i_pid_output_stage (
		.clk               (clk),
		.rst_n             (rst_n),
		.p_valid           (p_valid),
		.p_term            (p_term),
		.i_term            (i_term),
		.d_term            (d_term),
		.source_data_valid (source_data_valid),
		.source_data       (source_data)
	);

endmodule

/* testbench/pid_ref_model.svh */
`ifndef PID_REF_MODEL_SVH
`define PID_REF_MODEL_SVH

// Model state, the same history the controller keeps between samples
longint model_prev_err;
longint model_acc;
bit     model_first;

// State right after a reset
function automatic void model_reset();
	model_prev_err = 0;
	model_acc      = 0;
	model_first    = 1'b1;
endfunction

// Expected actuator value for one accepted sample
// Advances the model state as a side effect
function automatic out_t expected_output(
	input cmd_t  cmd,
	input alt_t  meas,
	input gain_t kp,
	input gain_t ki,
	input gain_t kd
);
	longint target;
	longint err;
	longint dlt;
	longint sum;
	longint scaled;
	longint limit;
	longint divisor;

	limit   = longint'(INT_LIMIT);
	divisor = longint'(1) << GAIN_FRAC;

	// Command byte counts in steps of 16 altitude units
	target = longint'(cmd) * (longint'(1) << SETPOINT_SHIFT);
	err    = target - longint'(meas);

	// No previous error right after reset
	if (model_first)
		dlt = 0;
	else
		dlt = err - model_prev_err;
	model_prev_err = err;
	model_first    = 1'b0;

	// Integrator with anti-windup clamp
	model_acc = model_acc + err;
	if (model_acc > limit)
		model_acc = limit;
	else if (model_acc < -limit)
		model_acc = -limit;

	sum = longint'(kp) * err + longint'(ki) * model_acc + longint'(kd) * dlt;

	// Floor division, rounds toward minus infinity
	scaled = sum / divisor;
	if (sum < 0 && (sum % divisor) != 0)
		scaled = scaled - 1;

	// Actuator range 0..OUT_MAX
	if (scaled < 0)
		scaled = 0;
	else if (scaled > longint'(OUT_MAX))
		scaled = longint'(OUT_MAX);

	return out_t'(scaled);
endfunction

`endif

/* testbench/pid_altitude_tb.sv */
`timescale 1ns/1ps

module pid_altitude_tb
	import pid_fmt_pkg::*;
	import pid_ctl_pkg::*;
();

	localparam int CLK_PERIOD    = 10;
	localparam int RESET_CYCLES  = 5;
	localparam int INTEG_SAMPLES = 270;
	localparam int N_RANDOM      = 200;
	// Idle cycles that empty the pipeline
	localparam int DRAIN         = PIPE_LATENCY + 3;
	localparam int TOTAL_SAMPLES = 2 + 2 + INTEG_SAMPLES + 4 + N_RANDOM;
	// Worst spacing of one sample, including drains and resets
	localparam int LONGEST_GAP   = 8;
	localparam int WATCHDOG_NS   = (TOTAL_SAMPLES * LONGEST_GAP + 100) * CLK_PERIOD;

	logic  clk;
	logic  rst_n;
	logic  sink_data_valid;
	cmd_t  sink_command;
	alt_t  sink_data;
	gain_t sink_kp;
	gain_t sink_ki;
	gain_t sink_kd;
	logic  source_data_valid;
	out_t  source_data;

	// Outstanding samples, expected value and the edge the DUT took it
	out_t   exp_q[$];
	int     accept_q[$];
	int     cycle = 0;
	int     value_errors = 0;
	int     latency_errors = 0;
	int     other_errors = 0;
	integer seed = 91;

	`include "pid_ref_model.svh"

	pid_altitude i_pid_altitude (
		.clk               (clk),
		.rst_n             (rst_n),
		.sink_data_valid   (sink_data_valid),
		.sink_command      (sink_command),
		.sink_data         (sink_data),
		.sink_kp           (sink_kp),
		.sink_ki           (sink_ki),
		.sink_kd           (sink_kd),
		.source_data_valid (source_data_valid),
		.source_data       (source_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic check_output(input out_t got, input out_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Mismatch source_data: got 0x%h, expected 0x%h at cycle %0d",
				got, exp, cycle);
		end
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp) begin
			latency_errors++;
			$display("Output arrived %0d cycles after its input instead of %0d, cycle %0d",
				got, exp, cycle);
		end
	endtask

	// One sample, valid stays high until the next task call changes it
	task automatic send_sample(input cmd_t cmd, input alt_t meas,
		input gain_t kp, input gain_t ki, input gain_t kd);
		@(posedge clk);
		sink_data_valid <= 1'b1;
		sink_command    <= cmd;
		sink_data       <= meas;
		sink_kp         <= kp;
		sink_ki         <= ki;
		sink_kd         <= kd;
		exp_q.push_back(expected_output(cmd, meas, kp, ki, kd));
		// DUT samples on the next edge
		accept_q.push_back(cycle + 1);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			sink_data_valid <= 1'b0;
		end
	endtask

	// Synchronous reset, model cleared alongside the DUT
	task automatic apply_reset();
		@(posedge clk);
		rst_n           <= 1'b0;
		sink_data_valid <= 1'b0;
		model_reset();
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	// Outputs sampled mid-cycle, away from the driving edge
	always @(negedge clk) begin : compare_outputs
		out_t exp_val;
		int   accept;
		if (source_data_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				other_errors++;
				$display("Output valid at cycle %0d with no sample outstanding", cycle);
			end else begin
				exp_val = exp_q.pop_front();
				accept  = accept_q.pop_front();
				check_output(source_data, exp_val);
				check_latency(cycle - accept, PIPE_LATENCY);
			end
		end else if (source_data_valid !== 1'b0) begin
			other_errors++;
			$display("Output valid is unknown at cycle %0d", cycle);
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

	initial begin : stimulus
		int    gap;
		cmd_t  cmd;
		alt_t  meas;
		gain_t kp;
		gain_t ki;
		gain_t kd;

		rst_n           = 1'b0;
		sink_data_valid = 1'b0;
		sink_command    = '0;
		sink_data       = '0;
		sink_kp         = '0;
		sink_ki         = '0;
		sink_kd         = '0;
		model_reset();
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		// Idle after reset, no output may appear
		idle_cycles(DRAIN);

		// Error -10, P -1000, floors to -16, clamps to 0
		send_sample(8'd60, 16'd970, 8'd100, 8'd0, 8'd0);
		// Error 60, P 6000, scaled to 93
		send_sample(8'd60, 16'd900, 8'd100, 8'd0, 8'd0);
		idle_cycles(DRAIN);

		// Large negative error, then a step up for a big D kick
		send_sample(8'd255, 16'd65535, 8'd0, 8'd0, 8'd0);
		send_sample(8'd255, 16'd0, 8'd255, 8'd0, 8'd255);
		idle_cycles(DRAIN);

		// Constant error 4080 with only ki, integrator hits its limit
		apply_reset();
		for (int i = 0; i < INTEG_SAMPLES; i++)
			send_sample(8'd255, 16'd0, 8'd0, 8'd1, 8'd0);
		idle_cycles(DRAIN);

		// Derivative only, first sample has no history
		apply_reset();
		send_sample(8'd100, 16'd1000, 8'd0, 8'd0, 8'd64);
		send_sample(8'd100, 16'd900, 8'd0, 8'd0, 8'd64);
		send_sample(8'd100, 16'd1100, 8'd0, 8'd0, 8'd64);
		send_sample(8'd100, 16'd700, 8'd0, 8'd0, 8'd64);
		idle_cycles(DRAIN);

		// Random traffic, gaps of 0 to 3 cycles
		for (int i = 0; i < N_RANDOM; i++) begin
			if (i == N_RANDOM / 2) begin
				idle_cycles(DRAIN);
				apply_reset();
			end
			gap  = $random(seed) & 3;
			cmd  = cmd_t'($random(seed));
			meas = alt_t'($random(seed) & 32'h1fff);
			kp   = gain_t'($random(seed));
			ki   = gain_t'($random(seed) & 32'h0f);
			kd   = gain_t'($random(seed));
			if (gap > 0)
				idle_cycles(gap);
			send_sample(cmd, meas, kp, ki, kd);
		end
		idle_cycles(DRAIN);

		if (exp_q.size() != 0) begin
			other_errors++;
			$display("%0d samples never came out of the DUT", exp_q.size());
		end

		$display("Errors: %0d value, %0d latency, %0d other",
			value_errors, latency_errors, other_errors);
		if (value_errors + latency_errors + other_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* pid_altitude.f */
+incdir+testbench
common/pid_fmt_pkg.sv
common/pid_ctl_pkg.sv
src/pid_error_calc.sv
src/pid_prop_path.sv
src/pid_integ_deriv_path.sv
src/pid_output_stage.sv
src/pid_altitude.sv
testbench/pid_altitude_tb.sv

/* Bender.yml */
package:
  name: pid_altitude

sources:
  - files:
      - common/pid_fmt_pkg.sv
      - common/pid_ctl_pkg.sv
      - src/pid_error_calc.sv
      - src/pid_prop_path.sv
      - src/pid_integ_deriv_path.sv
      - src/pid_output_stage.sv
      - src/pid_altitude.sv

  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/pid_altitude_tb.sv
